// File: rtl/id_defs.svh
`ifndef ID_DEFS_SVH
`define ID_DEFS_SVH

// Datapath widths
`define ID_INSTR_W      32
`define ID_DATA_W       32
`define ID_ALU_OP_W     8

// GPR address width and the paired read address
`define ID_GPR_AW       5
`define ID_GPR_PAIR_AW  (2 * `ID_GPR_AW)

// csr_num field of the CSR group
`define ID_CSR_NUM_W    14

// Major opcode in bits 31:24 for csrrd, csrwr and csrxchg
`define ID_CSR_OPC      8'h04

// Sub-op chosen by the rj field, anything else is csrxchg
`define ID_CSR_RD_SEL   5'd0
`define ID_CSR_WR_SEL   5'd1

// 3R group, value of bits 31:15
`define ID_OP3R_W       17
`define ID_OP3R_ADD     17'h00020
`define ID_OP3R_SUB     17'h00022
`define ID_OP3R_SLT     17'h00024
`define ID_OP3R_AND     17'h00029
`define ID_OP3R_OR      17'h0002a
`define ID_OP3R_XOR     17'h0002b

`endif

// File: rtl/id_pkg.sv
`include "id_defs.svh"

package id_pkg;

    // Opcodes handed to the execute stage
    typedef enum logic [`ID_ALU_OP_W-1:0] {
        ALU_NOP     = 8'h00,
        ALU_ADD     = 8'h01,
        ALU_SUB     = 8'h02,
        ALU_SLT     = 8'h03,
        ALU_AND     = 8'h04,
        ALU_OR      = 8'h05,
        ALU_XOR     = 8'h06,
        // CSR group lives in its own range
        ALU_CSRRD   = 8'h10,
        ALU_CSRWR   = 8'h11,
        ALU_CSRXCHG = 8'h12
    } alu_op_e;

    // One-entry buffer toward execute
    typedef enum logic [0:0] {
        OBUF_EMPTY = 1'b0,
        OBUF_FULL  = 1'b1
    } obuf_state_e;

endpackage

// File: rtl/decoder_csr.sv
`include "id_defs.svh"

// CSR group, {opcode[8], csr_num[14], rj[5], rd[5]}
// Purely combinational
module decoder_csr (
    input  logic [`ID_INSTR_W-1:0]     instr_i,

    // High when this decoder claims the instruction
    output logic                       hit_o,

    // GPR read, bit 0 is the first port in the low half of the address
    output logic [1:0]                 rd_valid_o,
    output logic [`ID_GPR_PAIR_AW-1:0] rd_addr_o,

    output logic [`ID_DATA_W-1:0]      imm_o,

    // GPR write to rd
    output logic                       wr_valid_o,
    output logic [`ID_GPR_AW-1:0]      wr_addr_o,

    output id_pkg::alu_op_e            alu_op_o
);

    logic [`ID_GPR_AW-1:0]   rd;
    logic [`ID_GPR_AW-1:0]   rj;
    logic [`ID_CSR_NUM_W-1:0] csr_num;

    assign rd      = instr_i[4:0];
    assign rj      = instr_i[9:5];
    assign csr_num = instr_i[23:10];

    always_comb begin
        // Nothing claimed by default
        hit_o      = 1'b0;
        rd_valid_o = 2'b00;
        rd_addr_o  = '0;
        imm_o      = '0;
        wr_valid_o = 1'b0;
        wr_addr_o  = '0;
        alu_op_o   = id_pkg::ALU_NOP;

        if (instr_i[31:24] == `ID_CSR_OPC) begin
            hit_o      = 1'b1;
            wr_valid_o = 1'b1;
            wr_addr_o  = rd;
            imm_o      = {{(`ID_DATA_W - `ID_CSR_NUM_W){1'b0}}, csr_num};

            // rj picks the flavour
            case (rj)
                `ID_CSR_RD_SEL: begin
                    alu_op_o = id_pkg::ALU_CSRRD;
                end
                `ID_CSR_WR_SEL: begin
                    alu_op_o   = id_pkg::ALU_CSRWR;
                    rd_valid_o = 2'b01;
                    rd_addr_o  = {{`ID_GPR_AW{1'b0}}, rd};
                end
                default: begin
                    // csrxchg, rj doubles as the mask register
                    alu_op_o   = id_pkg::ALU_CSRXCHG;
                    rd_valid_o = 2'b11;
                    rd_addr_o  = {rj, rd};
                end
            endcase
        end
    end

endmodule

// File: rtl/decoder_3r.sv
`include "id_defs.svh"

// 3R integer group, {opcode[17], rk[5], rj[5], rd[5]}
// Purely combinational
module decoder_3r (
    input  logic [`ID_INSTR_W-1:0]     instr_i,

    // High when bits 31:15 match one of the six ops
    output logic                       hit_o,

    // GPR read, rj on the first port and rk on the second
    output logic [1:0]                 rd_valid_o,
    output logic [`ID_GPR_PAIR_AW-1:0] rd_addr_o,

    // No immediate in this format
    output logic [`ID_DATA_W-1:0]      imm_o,

    // GPR write to rd
    output logic                       wr_valid_o,
    output logic [`ID_GPR_AW-1:0]      wr_addr_o,

    output id_pkg::alu_op_e            alu_op_o
);

    logic [`ID_GPR_AW-1:0] rd;
    logic [`ID_GPR_AW-1:0] rj;
    logic [`ID_GPR_AW-1:0] rk;
    logic [`ID_OP3R_W-1:0] opc;
    logic                  match;
    id_pkg::alu_op_e       op;

    assign rd  = instr_i[4:0];
    assign rj  = instr_i[9:5];
    assign rk  = instr_i[14:10];
    assign opc = instr_i[31:15];

    // Opcode lookup
    always_comb begin
        match = 1'b1;
        op    = id_pkg::ALU_NOP;
        case (opc)
            `ID_OP3R_ADD: op = id_pkg::ALU_ADD;
            `ID_OP3R_SUB: op = id_pkg::ALU_SUB;
            `ID_OP3R_SLT: op = id_pkg::ALU_SLT;
            `ID_OP3R_AND: op = id_pkg::ALU_AND;
            `ID_OP3R_OR:  op = id_pkg::ALU_OR;
            `ID_OP3R_XOR: op = id_pkg::ALU_XOR;
            default: begin
                match = 1'b0;
            end
        endcase
    end

    // Fields only leave the block on a match
    always_comb begin
        hit_o      = 1'b0;
        rd_valid_o = 2'b00;
        rd_addr_o  = '0;
        imm_o      = '0;
        wr_valid_o = 1'b0;
        wr_addr_o  = '0;
        alu_op_o   = id_pkg::ALU_NOP;

        if (match) begin
            hit_o      = 1'b1;
            rd_valid_o = 2'b11;
            rd_addr_o  = {rk, rj};
            wr_valid_o = 1'b1;
            wr_addr_o  = rd;
            alu_op_o   = op;
        end
    end

endmodule

// File: rtl/decode_merge.sv
`include "id_defs.svh"

module decode_merge (
    input  logic                       clk,
    input  logic                       arst_n_i,

    // CSR decoder result
    input  logic                       csr_hit_i,
    input  logic [1:0]                 csr_rd_valid_i,
    input  logic [`ID_GPR_PAIR_AW-1:0] csr_rd_addr_i,
    input  logic [`ID_DATA_W-1:0]      csr_imm_i,
    input  logic                       csr_wr_valid_i,
    input  logic [`ID_GPR_AW-1:0]      csr_wr_addr_i,
    input  id_pkg::alu_op_e            csr_alu_op_i,

    // 3R decoder result
    input  logic                       r3_hit_i,
    input  logic [1:0]                 r3_rd_valid_i,
    input  logic [`ID_GPR_PAIR_AW-1:0] r3_rd_addr_i,
    input  logic [`ID_DATA_W-1:0]      r3_imm_i,
    input  logic                       r3_wr_valid_i,
    input  logic [`ID_GPR_AW-1:0]      r3_wr_addr_i,
    input  id_pkg::alu_op_e            r3_alu_op_i,

    // From fetch
    input  logic                       instr_valid_i,
    input  logic [`ID_INSTR_W-1:0]     pc_i,
    output logic                       instr_ready_o,

    // To execute
    output logic                       dec_valid_o,
    input  logic                       dec_ready_i,
    output logic [`ID_INSTR_W-1:0]     dec_pc_o,
    output logic                       dec_illegal_o,
    output logic [1:0]                 dec_rd_valid_o,
    output logic [`ID_GPR_PAIR_AW-1:0] dec_rd_addr_o,
    output logic [`ID_DATA_W-1:0]      dec_imm_o,
    output logic                       dec_wr_valid_o,
    output logic [`ID_GPR_AW-1:0]      dec_wr_addr_o,
    output id_pkg::alu_op_e            dec_alu_op_o
);

    id_pkg::obuf_state_e        state_q;
    logic                       load;

    logic                       illegal;
    logic [1:0]                 rd_valid;
    logic [`ID_GPR_PAIR_AW-1:0] rd_addr;
    logic [`ID_DATA_W-1:0]      imm;
    logic                       wr_valid;
    logic [`ID_GPR_AW-1:0]      wr_addr;
    id_pkg::alu_op_e            alu_op;

    // Pick whichever decoder claimed it, zeros and NOP if none did
    always_comb begin
        illegal  = 1'b0;
        rd_valid = csr_rd_valid_i;
        rd_addr  = csr_rd_addr_i;
        imm      = csr_imm_i;
        wr_valid = csr_wr_valid_i;
        wr_addr  = csr_wr_addr_i;
        alu_op   = csr_alu_op_i;
        if (r3_hit_i) begin
            rd_valid = r3_rd_valid_i;
            rd_addr  = r3_rd_addr_i;
            imm      = r3_imm_i;
            wr_valid = r3_wr_valid_i;
            wr_addr  = r3_wr_addr_i;
            alu_op   = r3_alu_op_i;
        end else if (!csr_hit_i) begin
            illegal  = 1'b1;
            rd_valid = 2'b00;
            rd_addr  = '0;
            imm      = '0;
            wr_valid = 1'b0;
            wr_addr  = '0;
            alu_op   = id_pkg::ALU_NOP;
        end
    end

    // Accept when empty or when the current entry leaves this cycle
    assign instr_ready_o = (state_q == id_pkg::OBUF_EMPTY) || dec_ready_i;
    assign load          = instr_valid_i && instr_ready_o;
    assign dec_valid_o   = (state_q == id_pkg::OBUF_FULL);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= id_pkg::OBUF_EMPTY;
        end else if (load) begin
            state_q <= id_pkg::OBUF_FULL;
        end else if (dec_ready_i) begin
            state_q <= id_pkg::OBUF_EMPTY;
        end
    end

    // Payload only changes on a load
    always_ff @(posedge clk) begin
        if (load) begin
            dec_pc_o       <= pc_i;
            dec_illegal_o  <= illegal;
            dec_rd_valid_o <= rd_valid;
            dec_rd_addr_o  <= rd_addr;
            dec_imm_o      <= imm;
            dec_wr_valid_o <= wr_valid;
            dec_wr_addr_o  <= wr_addr;
            dec_alu_op_o   <= alu_op;
        end
    end

    // The two instruction groups must not overlap
    a_one_hit: assert property (@(posedge clk) disable iff (!arst_n_i)
        !(csr_hit_i && r3_hit_i));

    // Held result under back-pressure
    a_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
        dec_valid_o && !dec_ready_i |=> dec_valid_o
            && $stable({dec_pc_o, dec_illegal_o, dec_rd_valid_o, dec_rd_addr_o})
            && $stable({dec_imm_o, dec_wr_valid_o, dec_wr_addr_o, dec_alu_op_o}));

    a_rst_empty: assert property (@(posedge clk) !arst_n_i |=> !dec_valid_o);

endmodule

// File: rtl/id_stage.sv
`include "id_defs.svh"

// Decode stage top, both decoders side by side feeding the merge buffer
module id_stage (
    input  logic                       clk,
    input  logic                       arst_n_i,

    input  logic                       instr_valid_i,
    input  logic [`ID_INSTR_W-1:0]     instr_i,
    input  logic [`ID_INSTR_W-1:0]     pc_i,
    output logic                       instr_ready_o,

    output logic                       dec_valid_o,
    input  logic                       dec_ready_i,
    output logic [`ID_INSTR_W-1:0]     dec_pc_o,
    output logic                       dec_illegal_o,
    output logic [1:0]                 dec_rd_valid_o,
    output logic [`ID_GPR_PAIR_AW-1:0] dec_rd_addr_o,
    output logic [`ID_DATA_W-1:0]      dec_imm_o,
    output logic                       dec_wr_valid_o,
    output logic [`ID_GPR_AW-1:0]      dec_wr_addr_o,
    output id_pkg::alu_op_e            dec_alu_op_o
);

    logic                       csr_hit;
    logic [1:0]                 csr_rd_valid;
    logic [`ID_GPR_PAIR_AW-1:0] csr_rd_addr;
    logic [`ID_DATA_W-1:0]      csr_imm;
    logic                       csr_wr_valid;
    logic [`ID_GPR_AW-1:0]      csr_wr_addr;
    id_pkg::alu_op_e            csr_alu_op;

    logic                       r3_hit;
    logic [1:0]                 r3_rd_valid;
    logic [`ID_GPR_PAIR_AW-1:0] r3_rd_addr;
    logic [`ID_DATA_W-1:0]      r3_imm;
    logic                       r3_wr_valid;
    logic [`ID_GPR_AW-1:0]      r3_wr_addr;
    id_pkg::alu_op_e            r3_alu_op;

    decoder_csr u_decoder_csr (
        .instr_i    (instr_i),
        .hit_o      (csr_hit),
        .rd_valid_o (csr_rd_valid),
        .rd_addr_o  (csr_rd_addr),
        .imm_o      (csr_imm),
        .wr_valid_o (csr_wr_valid),
        .wr_addr_o  (csr_wr_addr),
        .alu_op_o   (csr_alu_op)
    );

    decoder_3r u_decoder_3r (
        .instr_i    (instr_i),
        .hit_o      (r3_hit),
        .rd_valid_o (r3_rd_valid),
        .rd_addr_o  (r3_rd_addr),
        .imm_o      (r3_imm),
        .wr_valid_o (r3_wr_valid),
        .wr_addr_o  (r3_wr_addr),
        .alu_op_o   (r3_alu_op)
    );

    decode_merge u_decode_merge (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .csr_hit_i      (csr_hit),
        .csr_rd_valid_i (csr_rd_valid),
        .csr_rd_addr_i  (csr_rd_addr),
        .csr_imm_i      (csr_imm),
        .csr_wr_valid_i (csr_wr_valid),
        .csr_wr_addr_i  (csr_wr_addr),
        .csr_alu_op_i   (csr_alu_op),
        .r3_hit_i       (r3_hit),
        .r3_rd_valid_i  (r3_rd_valid),
        .r3_rd_addr_i   (r3_rd_addr),
        .r3_imm_i       (r3_imm),
        .r3_wr_valid_i  (r3_wr_valid),
        .r3_wr_addr_i   (r3_wr_addr),
        .r3_alu_op_i    (r3_alu_op),
        .instr_valid_i  (instr_valid_i),
        .pc_i           (pc_i),
        .instr_ready_o  (instr_ready_o),
        .dec_valid_o    (dec_valid_o),
        .dec_ready_i    (dec_ready_i),
        .dec_pc_o       (dec_pc_o),
        .dec_illegal_o  (dec_illegal_o),
        .dec_rd_valid_o (dec_rd_valid_o),
        .dec_rd_addr_o  (dec_rd_addr_o),
        .dec_imm_o      (dec_imm_o),
        .dec_wr_valid_o (dec_wr_valid_o),
        .dec_wr_addr_o  (dec_wr_addr_o),
        .dec_alu_op_o   (dec_alu_op_o)
    );

endmodule

// File: verif/tb_id_stage.sv
`include "id_defs.svh"

module tb_id_stage;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD  = 4;
    localparam int NUM_FULL    = 40;
    localparam int NUM_BP      = 360;
    localparam int NUM_INSTR   = NUM_FULL + NUM_BP;
    localparam int WATCHDOG_NS = NUM_INSTR * 20 * CLK_PERIOD;

    // Expected decode result of one instruction
    typedef struct packed {
        logic [`ID_INSTR_W-1:0]     pc;
        logic                       illegal;
        logic [1:0]                 rd_valid;
        logic [`ID_GPR_PAIR_AW-1:0] rd_addr;
        logic [`ID_DATA_W-1:0]      imm;
        logic                       wr_valid;
        logic [`ID_GPR_AW-1:0]      wr_addr;
        id_pkg::alu_op_e            alu_op;
    } exp_t;

    logic                       clk = 1'b0;
    logic                       arst_n_i;
    logic                       instr_valid_i;
    logic [`ID_INSTR_W-1:0]     instr_i;
    logic [`ID_INSTR_W-1:0]     pc_i;
    logic                       instr_ready_o;
    logic                       dec_valid_o;
    logic                       dec_ready_i;
    logic [`ID_INSTR_W-1:0]     dec_pc_o;
    logic                       dec_illegal_o;
    logic [1:0]                 dec_rd_valid_o;
    logic [`ID_GPR_PAIR_AW-1:0] dec_rd_addr_o;
    logic [`ID_DATA_W-1:0]      dec_imm_o;
    logic                       dec_wr_valid_o;
    logic [`ID_GPR_AW-1:0]      dec_wr_addr_o;
    id_pkg::alu_op_e            dec_alu_op_o;

    integer seed = 32'hf280_e21f;
    int     errors = 0;
    int     in_count = 0;
    int     out_count = 0;
    int     illegal_seen = 0;
    int     op_seen [256];

    exp_t   exp_q [$];
    exp_t   exp_head = '0;
    logic   exp_vld = 1'b0;
    logic   in_xfer;
    logic   out_xfer;

    always #(CLK_PERIOD / 2) clk = ~clk;

    id_stage u_dut (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .instr_valid_i  (instr_valid_i),
        .instr_i        (instr_i),
        .pc_i           (pc_i),
        .instr_ready_o  (instr_ready_o),
        .dec_valid_o    (dec_valid_o),
        .dec_ready_i    (dec_ready_i),
        .dec_pc_o       (dec_pc_o),
        .dec_illegal_o  (dec_illegal_o),
        .dec_rd_valid_o (dec_rd_valid_o),
        .dec_rd_addr_o  (dec_rd_addr_o),
        .dec_imm_o      (dec_imm_o),
        .dec_wr_valid_o (dec_wr_valid_o),
        .dec_wr_addr_o  (dec_wr_addr_o),
        .dec_alu_op_o   (dec_alu_op_o)
    );

    assign in_xfer  = instr_valid_i && instr_ready_o;
    assign out_xfer = dec_valid_o && dec_ready_i;

    // Mix of CSR words, 3R words and random words
    function automatic logic [31:0] make_instr();
        logic [31:0] r;
        logic [31:0] s;
        logic [4:0]  rj;
        logic [16:0] op;
        r = $random(seed);
        s = $random(seed);
        case (r[1:0])
            2'd0: begin
                // rj 0 and 1 weighted up so all three CSR ops show up
                case (s[31:30])
                    2'd0:    rj = `ID_CSR_RD_SEL;
                    2'd1:    rj = `ID_CSR_WR_SEL;
                    default: rj = s[9:5];
                endcase
                return {`ID_CSR_OPC, s[23:10], rj, s[4:0]};
            end
            2'd1: begin
                case (r[4:2])
                    3'd0:    op = `ID_OP3R_ADD;
                    3'd1:    op = `ID_OP3R_SUB;
                    3'd2:    op = `ID_OP3R_SLT;
                    3'd3:    op = `ID_OP3R_AND;
                    3'd4:    op = `ID_OP3R_OR;
                    default: op = `ID_OP3R_XOR;
                endcase
                return {op, s[14:0]};
            end
            default: begin
                return s;
            end
        endcase
    endfunction

    // Reference model of the decode rules
    function automatic exp_t ref_decode(input logic [31:0] instr, input logic [31:0] pc);
        exp_t       e;
        logic [4:0] rd;
        logic [4:0] rj;
        logic [4:0] rk;
        e    = '0;
        e.pc = pc;
        rd   = instr[4:0];
        rj   = instr[9:5];
        rk   = instr[14:10];
        if (instr[31:24] == `ID_CSR_OPC) begin
            e.wr_valid = 1'b1;
            e.wr_addr  = rd;
            e.imm      = {18'd0, instr[23:10]};
            if (rj == `ID_CSR_RD_SEL) begin
                e.alu_op = id_pkg::ALU_CSRRD;
            end else if (rj == `ID_CSR_WR_SEL) begin
                e.alu_op   = id_pkg::ALU_CSRWR;
                e.rd_valid = 2'b01;
                e.rd_addr  = {5'd0, rd};
            end else begin
                e.alu_op   = id_pkg::ALU_CSRXCHG;
                e.rd_valid = 2'b11;
                e.rd_addr  = {rj, rd};
            end
        end else begin
            case (instr[31:15])
                `ID_OP3R_ADD: e.alu_op = id_pkg::ALU_ADD;
                `ID_OP3R_SUB: e.alu_op = id_pkg::ALU_SUB;
                `ID_OP3R_SLT: e.alu_op = id_pkg::ALU_SLT;
                `ID_OP3R_AND: e.alu_op = id_pkg::ALU_AND;
                `ID_OP3R_OR:  e.alu_op = id_pkg::ALU_OR;
                `ID_OP3R_XOR: e.alu_op = id_pkg::ALU_XOR;
                default:      e.illegal = 1'b1;
            endcase
            if (!e.illegal) begin
                e.rd_valid = 2'b11;
                e.rd_addr  = {rk, rj};
                e.wr_valid = 1'b1;
                e.wr_addr  = rd;
            end
        end
        return e;
    endfunction

    // Scoreboard queue, head is registered for the assertions
    always @(posedge clk) begin
        if (arst_n_i) begin
            if (out_xfer) begin
                if (exp_q.size() != 0) begin
                    void'(exp_q.pop_front());
                end
                out_count++;
                op_seen[dec_alu_op_o]++;
                if (dec_illegal_o) begin
                    illegal_seen++;
                end
            end
            if (in_xfer) begin
                exp_q.push_back(ref_decode(instr_i, pc_i));
                in_count++;
            end
            if (exp_q.size() != 0) begin
                exp_head <= exp_q[0];
                exp_vld  <= 1'b1;
            end else begin
                exp_vld  <= 1'b0;
            end
        end
    end

    a_rst_low: assert property (@(posedge clk) !arst_n_i |-> !dec_valid_o)
        else begin
            errors++;
            $display("dec_valid_o was high during reset");
        end

    a_rst_rdy: assert property (@(posedge clk) $rose(arst_n_i) |-> instr_ready_o && !dec_valid_o)
        else begin
            errors++;
            $display("Stage not empty and ready right after reset");
        end

    a_rdy_empty: assert property (@(posedge clk) disable iff (!arst_n_i)
        !dec_valid_o |-> instr_ready_o)
        else begin
            errors++;
            $display("instr_ready_o low although the output buffer is empty");
        end

    // Full throughput whenever execute is ready
    a_rdy_thru: assert property (@(posedge clk) disable iff (!arst_n_i)
        dec_ready_i |-> instr_ready_o)
        else begin
            errors++;
            $display("Fetch was stalled while execute was ready");
        end

    a_latency: assert property (@(posedge clk) disable iff (!arst_n_i)
        in_xfer |=> dec_valid_o)
        else begin
            errors++;
            $display("Accepted instruction was not presented on the next cycle");
        end

    a_expected: assert property (@(posedge clk) disable iff (!arst_n_i) out_xfer |-> exp_vld)
        else begin
            errors++;
            $display("Result delivered with no instruction outstanding");
        end

    a_pc: assert property (@(posedge clk) disable iff (!arst_n_i)
        out_xfer && exp_vld |-> dec_pc_o == exp_head.pc)
        else begin
            errors++;
            $display("FAIL dec_pc_o expected %h got %h", $sampled(exp_head.pc),
                $sampled(dec_pc_o));
        end

    a_illegal: assert property (@(posedge clk) disable iff (!arst_n_i)
        out_xfer && exp_vld |-> dec_illegal_o == exp_head.illegal)
        else begin
            errors++;
            $display("FAIL dec_illegal_o expected %h got %h", $sampled(exp_head.illegal),
                $sampled(dec_illegal_o));
        end

    a_rd_valid: assert property (@(posedge clk) disable iff (!arst_n_i)
        out_xfer && exp_vld |-> dec_rd_valid_o == exp_head.rd_valid)
        else begin
            errors++;
            $display("FAIL dec_rd_valid_o expected %h got %h", $sampled(exp_head.rd_valid),
                $sampled(dec_rd_valid_o));
        end

    a_rd_addr: assert property (@(posedge clk) disable iff (!arst_n_i)
        out_xfer && exp_vld |-> dec_rd_addr_o == exp_head.rd_addr)
        else begin
            errors++;
            $display("FAIL dec_rd_addr_o expected %h got %h", $sampled(exp_head.rd_addr),
                $sampled(dec_rd_addr_o));
        end

    a_imm: assert property (@(posedge clk) disable iff (!arst_n_i)
        out_xfer && exp_vld |-> dec_imm_o == exp_head.imm)
        else begin
            errors++;
            $display("FAIL dec_imm_o expected %h got %h", $sampled(exp_head.imm),
                $sampled(dec_imm_o));
        end

    a_wr_valid: assert property (@(posedge clk) disable iff (!arst_n_i)
        out_xfer && exp_vld |-> dec_wr_valid_o == exp_head.wr_valid)
        else begin
            errors++;
            $display("FAIL dec_wr_valid_o expected %h got %h", $sampled(exp_head.wr_valid),
                $sampled(dec_wr_valid_o));
        end

    a_wr_addr: assert property (@(posedge clk) disable iff (!arst_n_i)
        out_xfer && exp_vld |-> dec_wr_addr_o == exp_head.wr_addr)
        else begin
            errors++;
            $display("FAIL dec_wr_addr_o expected %h got %h", $sampled(exp_head.wr_addr),
                $sampled(dec_wr_addr_o));
        end

    a_alu_op: assert property (@(posedge clk) disable iff (!arst_n_i)
        out_xfer && exp_vld |-> dec_alu_op_o == exp_head.alu_op)
        else begin
            errors++;
            $display("FAIL dec_alu_op_o expected %h got %h", $sampled(exp_head.alu_op),
                $sampled(dec_alu_op_o));
        end

    // Feed count instructions, optionally with random valid gaps and back-pressure
    task automatic run_phase(input int count, input bit backpressure);
        int          sent;
        bit          held;
        bit          go;
        logic [31:0] r;
        sent = 0;
        held = 1'b0;
        while (sent < count) begin
            @(negedge clk);
            r = $random(seed);
            if (backpressure) begin
                dec_ready_i = r[0];
                go          = r[1] | r[2];
            end else begin
                dec_ready_i = 1'b1;
                go          = 1'b1;
            end
            // Word must stay put until it is taken
            if (!held) begin
                if (go) begin
                    instr_i       = make_instr();
                    pc_i          = pc_i + 32'd4;
                    instr_valid_i = 1'b1;
                end else begin
                    instr_valid_i = 1'b0;
                end
            end
            @(posedge clk);
            if (instr_valid_i && instr_ready_o) begin
                sent++;
                held = 1'b0;
            end else begin
                held = instr_valid_i;
            end
        end
    endtask

    task automatic drain();
        @(negedge clk);
        instr_valid_i = 1'b0;
        dec_ready_i   = 1'b1;
        while (dec_valid_o || exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
    endtask

    task automatic final_checks();
        id_pkg::alu_op_e op;
        if (in_count != out_count) begin
            errors++;
            $display("Accepted %0d instructions but delivered %0d results", in_count, out_count);
        end
        if (illegal_seen == 0) begin
            errors++;
            $display("No illegal instruction reached the output");
        end
        op = op.first();
        repeat (op.num()) begin
            if (op_seen[op] == 0) begin
                errors++;
                $display("Opcode %s was never delivered", op.name());
            end
            op = op.next();
        end
    endtask

    initial begin
        arst_n_i      = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        pc_i          = 32'h1c00_0000;
        dec_ready_i   = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n_i = 1'b1;
        run_phase(NUM_FULL, 1'b0);
        run_phase(NUM_BP, 1'b1);
        drain();
        final_checks();
        $display("Done: %0d accepted, %0d delivered, %0d errors", in_count, out_count, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout after %0d ns with results still outstanding, %0d errors",
            WATCHDOG_NS, errors);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// File: id_stage.f
+incdir+rtl
rtl/id_pkg.sv
rtl/decoder_csr.sv
rtl/decoder_3r.sv
rtl/decode_merge.sv
rtl/id_stage.sv
verif/tb_id_stage.sv

// File: Makefile
# Verilator flow for the decode stage

VERILATOR ?= verilator
FILELIST  ?= id_stage.f
TB_TOP    ?= tb_id_stage
RTL_TOP   ?= id_stage
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --assert --timing --timescale $(TIMESCALE)
PASS_MSG  ?= TESTBENCH PASSED

SIM_BIN := $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(SIM_BIN): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(OBJ_DIR) -o V$(TB_TOP)

# Output is shown and then searched for the pass line
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(OBJ_DIR) -o V$(TB_TOP)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
